// File: list.f
+incdir+src
src/fpa_data_pkg.sv
src/fpa_ctrl_pkg.sv
src/alu181.sv
src/carry182.sv
src/fpa_sum.sv
src/fpa_regs.sv
src/fpa.sv
testbench/tb_fpa.sv

// File: run.sh
#!/bin/sh
# build and run the fpa testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_fpa -o sim_fpa
./obj_dir/sim_fpa > sim.log
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: src/alu181.sv
/*
	4-bit arithmetic slice, active-high data.
	Carry in, carry out, group generate and propagate are active low.
	Only the arithmetic functions are built; there is no logic mode.
*/

module alu181 import fpa_data_pkg::*, fpa_ctrl_pkg::*; (
	input  nib_t    a,
	input  nib_t    b,
	input  alu_fn_t s,
	input  logic    cn_,
	output nib_t    f,
	output logic    g,
	output logic    p,
	output logic    co_
);

	// f = x plus y plus carry, where y is only ever set together with x
	nib_t x;
	nib_t y;

	// cy[4] enters bit 3, cy[0] leaves bit 0
	logic [0:4] cy;
	logic       grp_g;

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			x[i] = a[i] | (b[i] & s[0]) | (~b[i] & s[1]);
			y[i] = a[i] & ((~b[i] & s[2]) | (b[i] & s[3]));
		end
	end

	always_comb begin
		cy[4] = ~cn_;
		for (int i = 3; i >= 0; i--) begin
			cy[i] = y[i] | (x[i] & cy[i+1]);
			f[i] = x[i] ^ y[i] ^ cy[i+1];
		end
	end

	// group terms for the look-ahead unit
	assign grp_g = y[0]
		| (x[0] & y[1])
		| (x[0] & x[1] & y[2])
		| (x[0] & x[1] & x[2] & y[3]);

	assign g = ~grp_g;
	assign p = ~(&x);
	assign co_ = ~cy[0];

endmodule

// File: src/carry182.sv
/*
	Carry look-ahead over four slices, all signals active low.
	Element 3 of g and p is the least significant group.
*/

module carry182 import fpa_data_pkg::*; (
	input  logic cn_,
	input  nib_t g,
	input  nib_t p,
	output logic c1_,
	output logic c2_,
	output logic c3_
);

	logic c0;
	logic g0, g1, g2;
	logic p0, p1, p2;

	// group 0 sits at the low end of the span
	assign c0 = ~cn_;
	assign g0 = ~g[3];
	assign g1 = ~g[2];
	assign g2 = ~g[1];
	assign p0 = ~p[3];
	assign p1 = ~p[2];
	assign p2 = ~p[1];

	assign c1_ = ~(g0 | (p0 & c0));
	assign c2_ = ~(g1 | (p1 & g0) | (p1 & p0 & c0));
	assign c3_ = ~(g2 | (p2 & g1) | (p2 & p1 & g0) | (p2 & p1 & p0 & c0));

endmodule

// File: src/fpa.sv
/*
	Arithmetic datapath of the 40-bit FPU, without its sequencer.
	Register changes take one clock; sum, carries, zp and the zero
	detects are combinational. Controls are active-high levels.
*/

`include "fpa_cfg.svh"

module fpa import fpa_data_pkg::*, fpa_ctrl_pkg::*; (
	input  logic      clockm_,
	input  logic      _0_t_,
	input  treg_op_t  t_op,
	input  mreg_op_t  m_op,
	input  creg_op_t  c_op,
	input  kbus_sel_t k_sel,
	input  alu_fn_t   fn_hi,
	input  alu_fn_t   fn_lo,
	input  zp_sel_t   zp_sel,
	input  logic      zp_clear,
	input  logic      t_in,
	input  logic      t_fill,
	input  logic      m_in,
	input  logic      cin_a,
	input  logic      cin_b,
	input  logic      cin_c,
	input  half_t     w,
	input  byte_t     d,
	input  logic      z_f,
	input  logic      m_f,
	input  logic      v_f,
	input  logic      c_f,
	output half_t     zp,
	output logic      t_zero_hi,
	output logic      t_zero_mid,
	output logic      t_zero_low,
	output logic      t_sign,
	output logic      c_sign,
	output logic      m_sign,
	output logic      cout_a,
	output logic      cout_b,
	output logic      cout_c
);

	// width of the low segment of T
	localparam int LOW_W = `FPA_W - `FPA_SEG_B;

	word_t t;
	word_t m;
	word_t c;
	word_t k;
	word_t sum;

	fpa_regs u_regs (
		.clockm_ (clockm_),
		._0_t_   (_0_t_),
		.t_op    (t_op),
		.m_op    (m_op),
		.c_op    (c_op),
		.k       (k),
		.t_in    (t_in),
		.t_fill  (t_fill),
		.m_in    (m_in),
		.t       (t),
		.m       (m),
		.c       (c)
	);

	fpa_sum u_sum (
		.a      (t),
		.b      (c),
		.fn_hi  (fn_hi),
		.fn_lo  (fn_lo),
		.cin_a  (cin_a),
		.cin_b  (cin_b),
		.cin_c  (cin_c),
		.sum    (sum),
		.cout_a (cout_a),
		.cout_b (cout_b),
		.cout_c (cout_c)
	);

	// K bus into T
	always_comb begin
		case (k_sel)
			K_SUM: k = sum;
			K_M: k = m;
			// w fills both upper fields, its top byte the low field
			K_W: k = {w, w, w[0:LOW_W-1]};
			default: k = '0;
		endcase
	end

	// readout, clear wins over any select
	always_comb begin
		if (zp_clear) begin
			zp = '0;
		end else begin
			case (zp_sel)
				ZP_HI: zp = t[0:`FPA_SEG_A-1];
				ZP_MID: zp = t[`FPA_SEG_A:`FPA_SEG_B-1];
				ZP_LOW: zp = {t[`FPA_SEG_B:`FPA_W-1], d};
				default: zp = {z_f, m_f, v_f, c_f, 12'b0};
			endcase
		end
	end

	// field zero detects of T
	assign t_zero_hi = ~|t[0:`FPA_SEG_A-1];
	assign t_zero_mid = ~|t[`FPA_SEG_A:`FPA_SEG_B-1];
	assign t_zero_low = ~|t[`FPA_SEG_B:`FPA_W-1];

	assign t_sign = t[0];
	assign c_sign = c[0];
	assign m_sign = m[0];

endmodule

// File: src/fpa_cfg.svh
/*
	Datapath widths and carry segment boundaries.
	Bit 0 is the most significant bit, so segments are listed from the top.
	The two look-ahead segments must each be 16 bits wide.
*/

`ifndef FPA_CFG_SVH
`define FPA_CFG_SVH

// full register width
`define FPA_W 40

// first bit of the middle and of the low carry segment
`define FPA_SEG_A 16
`define FPA_SEG_B 32

// width of the zp readout and of the w input
`define FPA_ZP_W 16

`endif

// File: src/fpa_ctrl_pkg.sv
/*
	Control encodings for the datapath.
	All fields are active high and sampled on the rising clock edge.
*/

package fpa_ctrl_pkg;

	typedef enum logic [1:0] {
		T_HOLD = 2'b00,
		T_SHR  = 2'b01,
		T_SHL  = 2'b10,
		T_LOAD = 2'b11
	} treg_op_t;

	// code 2'b11 is unused and holds M
	typedef enum logic [1:0] {
		M_HOLD = 2'b00,
		M_SHR  = 2'b01,
		M_LOAD = 2'b10
	} mreg_op_t;

	typedef enum logic [1:0] {
		C_HOLD = 2'b00,
		C_LOAD = 2'b01,
		C_SAR  = 2'b10
	} creg_op_t;

	typedef enum logic [1:0] {
		K_SUM  = 2'b00,
		K_M    = 2'b01,
		K_W    = 2'b10,
		K_ZERO = 2'b11
	} kbus_sel_t;

	// slice select codes, arithmetic mode only
	typedef enum logic [3:0] {
		ALU_PASS = 4'b0000,
		ALU_SUB  = 4'b0110,
		ALU_ADD  = 4'b1001,
		ALU_DEC  = 4'b1111
	} alu_fn_t;

	typedef enum logic [1:0] {
		ZP_HI    = 2'b00,
		ZP_MID   = 2'b01,
		ZP_LOW   = 2'b10,
		ZP_FLAGS = 2'b11
	} zp_sel_t;

endpackage

// File: src/fpa_data_pkg.sv
/*
	Vector types for the datapath.
	All vectors are ascending, with bit 0 as the MSB.
*/

`include "fpa_cfg.svh"

package fpa_data_pkg;

	// T, M, C and the K bus
	typedef logic [0:`FPA_W-1] word_t;

	// w input and zp readout
	typedef logic [0:`FPA_ZP_W-1] half_t;

	// d input, shown beside the low byte of T
	typedef logic [0:7] byte_t;

	// one alu slice operand, bit 3 is the LSB
	typedef logic [0:3] nib_t;

endpackage

// File: src/fpa_regs.sv
/*
	T, M and C registers on one clock with a shared asynchronous clear.
	All three sample the values held before the edge, so T can move into
	M or C in the same cycle that T itself is reloaded.
*/

`include "fpa_cfg.svh"

module fpa_regs import fpa_data_pkg::*, fpa_ctrl_pkg::*; (
	input  logic     clockm_,
	input  logic     _0_t_,
	input  treg_op_t t_op,
	input  mreg_op_t m_op,
	input  creg_op_t c_op,
	input  word_t    k,
	input  logic     t_in,
	input  logic     t_fill,
	input  logic     m_in,
	output word_t    t,
	output word_t    m,
	output word_t    c
);

	// accumulator
	always_ff @(posedge clockm_ or negedge _0_t_) begin
		if (!_0_t_) begin
			t <= '0;
		end else begin
			case (t_op)
				T_HOLD: t <= t;
				// toward bit 39, t_in enters at the top
				T_SHR: t <= {t_in, t[0:`FPA_W-2]};
				// toward bit 0, t_fill enters at the bottom
				T_SHL: t <= {t[1:`FPA_W-1], t_fill};
				T_LOAD: t <= k;
				default: t <= t;
			endcase
		end
	end

	// multiplier / quotient
	always_ff @(posedge clockm_ or negedge _0_t_) begin
		if (!_0_t_) begin
			m <= '0;
		end else begin
			case (m_op)
				M_HOLD: m <= m;
				M_SHR: m <= {m_in, m[0:`FPA_W-2]};
				M_LOAD: m <= t;
				default: m <= m;
			endcase
		end
	end

	// operand
	always_ff @(posedge clockm_ or negedge _0_t_) begin
		if (!_0_t_) begin
			c <= '0;
		end else begin
			case (c_op)
				C_HOLD: c <= c;
				C_LOAD: c <= t;
				// arithmetic shift, sign bit copied down
				C_SAR: c <= {c[0], c[0:`FPA_W-2]};
				default: c <= c;
			endcase
		end
	end

endmodule

// File: src/fpa_sum.sv
/*
	Segmented 40-bit adder, purely combinational.
	Segments 0-15 and 16-31 use look-ahead, 32-39 ripples two slices.
	No carry crosses a segment boundary; carries here are active high.
*/

`include "fpa_cfg.svh"

module fpa_sum import fpa_data_pkg::*, fpa_ctrl_pkg::*; (
	input  word_t   a,
	input  word_t   b,
	input  alu_fn_t fn_hi,
	input  alu_fn_t fn_lo,
	input  logic    cin_a,
	input  logic    cin_b,
	input  logic    cin_c,
	output word_t   sum,
	output logic    cout_a,
	output logic    cout_b,
	output logic    cout_c
);

	// per look-ahead segment: function, carry in, carry out
	alu_fn_t    seg_fn [0:1];
	logic [0:1] seg_cin;
	logic [0:1] seg_cout;

	assign seg_fn[0] = fn_hi;
	assign seg_fn[1] = fn_lo;
	assign seg_cin = {cin_a, cin_b};
	assign cout_a = seg_cout[0];
	assign cout_b = seg_cout[1];

	for (genvar sg = 0; sg < 2; sg++) begin : g_la
		localparam int BASE = sg * `FPA_SEG_A;

		nib_t       gn;
		nib_t       pn;
		logic [0:3] cn_s;
		logic [0:3] co_s;

		// slice 3 takes the segment carry, the others come from the look-ahead
		assign cn_s[3] = ~seg_cin[sg];
		assign seg_cout[sg] = ~co_s[0];

		carry182 u_la (
			.cn_ (cn_s[3]),
			.g   (gn),
			.p   (pn),
			.c1_ (cn_s[2]),
			.c2_ (cn_s[1]),
			.c3_ (cn_s[0])
		);

		for (genvar j = 0; j < 4; j++) begin : g_slice
			alu181 u_alu (
				.a   (a[BASE+4*j +: 4]),
				.b   (b[BASE+4*j +: 4]),
				.s   (seg_fn[sg]),
				.cn_ (cn_s[j]),
				.f   (sum[BASE+4*j +: 4]),
				.g   (gn[j]),
				.p   (pn[j]),
				.co_ (co_s[j])
			);
		end
	end

	// low segment, two slices in ripple
	logic c_mid_;
	logic c_top_;

	alu181 u_alu_c_lo (
		.a   (a[`FPA_SEG_B+4 +: 4]),
		.b   (b[`FPA_SEG_B+4 +: 4]),
		.s   (fn_lo),
		.cn_ (~cin_c),
		.f   (sum[`FPA_SEG_B+4 +: 4]),
		.g   (),
		.p   (),
		.co_ (c_mid_)
	);

	alu181 u_alu_c_hi (
		.a   (a[`FPA_SEG_B +: 4]),
		.b   (b[`FPA_SEG_B +: 4]),
		.s   (fn_lo),
		.cn_ (c_mid_),
		.f   (sum[`FPA_SEG_B +: 4]),
		.g   (),
		.p   (),
		.co_ (c_top_)
	);

	assign cout_c = ~c_top_;

endmodule

// File: testbench/tb_fpa.sv
/*
	Testbench for the fpa datapath. It drives the controls in place of the sequencer.
	Expected sums come from a per-segment model of the slice functions.
	Inputs change on the rising edge, and outputs are checked on the falling edge.
*/

module tb_fpa import fpa_data_pkg::*, fpa_ctrl_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NROWS = 16;

	typedef struct packed {
		half_t      w1;
		half_t      w2;
		alu_fn_t    fn_hi;
		alu_fn_t    fn_lo;
		logic [0:2] cin;
		logic       t_in;
		word_t      exp;
		logic [0:2] cout;
	} row_t;

	logic clockm_;
	logic _0_t_;
	treg_op_t t_op;
	mreg_op_t m_op;
	creg_op_t c_op;
	kbus_sel_t k_sel;
	alu_fn_t fn_hi, fn_lo;
	zp_sel_t zp_sel;
	logic zp_clear, t_in, t_fill, m_in, cin_a, cin_b, cin_c;
	half_t w;
	byte_t d;
	logic z_f, m_f, v_f, c_f;
	half_t zp;
	logic t_zero_hi, t_zero_mid, t_zero_low, t_sign, c_sign, m_sign;
	logic cout_a, cout_b, cout_c;

	row_t rows [0:NROWS-1];
	alu_fn_t fn_codes [0:3];
	logic [31:0] rng;
	string test_name;
	int errors, test_err0, tests_passed, tests_failed;

	fpa UUT (.*);

	always #2 clockm_ = ~clockm_;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// T contents after a K_W load
	function automatic word_t w_word(input half_t v);
		return {v, v, v[0:7]};
	endfunction

	// one carry segment whose width is set by mask
	function automatic logic [16:0] seg_add(input logic [15:0] a, input logic [15:0] b,
			input alu_fn_t fn, input logic cin, input logic [15:0] mask);
		logic [15:0] op;
		case (fn)
			ALU_ADD: op = b;
			ALU_SUB: op = ~b & mask;
			ALU_DEC: op = mask;
			default: op = '0;
		endcase
		return {1'b0, a} + {1'b0, op} + {16'b0, cin};
	endfunction

	function automatic void seg_model(input word_t a, input word_t b, input alu_fn_t fh,
			input alu_fn_t fl, input logic [0:2] cin, output word_t res, output logic [0:2] co);
		logic [16:0] s_a, s_b, s_c;
		s_a = seg_add(a[0:15], b[0:15], fh, cin[0], 16'hffff);
		s_b = seg_add(a[16:31], b[16:31], fl, cin[1], 16'hffff);
		s_c = seg_add({8'h00, a[32:39]}, {8'h00, b[32:39]}, fl, cin[2], 16'h00ff);
		res = {s_a[15:0], s_b[15:0], s_c[7:0]};
		co = {s_a[16], s_b[16], s_c[8]};
	endfunction

	task automatic fill_row(input int i, input half_t w1, input half_t w2, input alu_fn_t fh,
			input alu_fn_t fl, input logic [0:2] cin, input logic ti);
		rows[i].w1 = w1;
		rows[i].w2 = w2;
		rows[i].fn_hi = fh;
		rows[i].fn_lo = fl;
		rows[i].cin = cin;
		rows[i].t_in = ti;
	endtask

	task automatic build_table();
		word_t res;
		logic [0:2] co;
		fn_codes[0] = ALU_PASS;
		fn_codes[1] = ALU_ADD;
		fn_codes[2] = ALU_SUB;
		fn_codes[3] = ALU_DEC;
		// carry edge cases per function
		fill_row(0, 16'hFFFF, 16'h0001, ALU_ADD, ALU_ADD, 3'b000, 1'b1);
		fill_row(1, 16'hFFFF, 16'hFFFF, ALU_ADD, ALU_ADD, 3'b111, 1'b0);
		fill_row(2, 16'h1234, 16'h1234, ALU_SUB, ALU_SUB, 3'b111, 1'b1);
		fill_row(3, 16'h1234, 16'h1234, ALU_SUB, ALU_SUB, 3'b000, 1'b0);
		fill_row(4, 16'h5555, 16'hFFFF, ALU_PASS, ALU_PASS, 3'b111, 1'b1);
		fill_row(5, 16'h0F0F, 16'h0000, ALU_DEC, ALU_DEC, 3'b000, 1'b0);
		fill_row(6, 16'h0F0F, 16'h8000, ALU_DEC, ALU_DEC, 3'b111, 1'b1);
		fill_row(7, 16'h7FFF, 16'h0001, ALU_ADD, ALU_SUB, 3'b010, 1'b0);
		for (int i = 8; i < NROWS; i++) begin
			rng = xorshift(rng);
			fill_row(i, rng[15:0], rng[31:16], ALU_PASS, ALU_PASS, 3'b000, 1'b0);
			rng = xorshift(rng);
			rows[i].fn_hi = fn_codes[rng[1:0]];
			rows[i].fn_lo = fn_codes[rng[3:2]];
			rows[i].cin = rng[6:4];
			rows[i].t_in = rng[7];
		end
		// T holds the second word, C the first
		for (int i = 0; i < NROWS; i++) begin
			seg_model(w_word(rows[i].w2), w_word(rows[i].w1), rows[i].fn_hi, rows[i].fn_lo,
				rows[i].cin, res, co);
			rows[i].exp = res;
			rows[i].cout = co;
		end
	endtask

	task automatic check_half(input string sig, input half_t got, input half_t exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string sig, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %b, expected %b", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		if (errors == test_err0) begin
			$display("test %s: passed", test_name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", test_name, errors - test_err0);
			tests_failed++;
		end
	endtask

	// one register operation that is done when the task returns on a falling edge
	task automatic run_op(input treg_op_t top, input mreg_op_t mop, input creg_op_t cop,
			input kbus_sel_t ks);
		@(posedge clockm_);
		t_op <= top;
		m_op <= mop;
		c_op <= cop;
		k_sel <= ks;
		@(posedge clockm_);
		t_op <= T_HOLD;
		m_op <= M_HOLD;
		c_op <= C_HOLD;
		@(negedge clockm_);
	endtask

	// T through the three zp slices, the zero detects and t_sign
	task automatic verify_t(input word_t exp);
		@(posedge clockm_);
		zp_clear <= 1'b0;
		zp_sel <= ZP_HI;
		@(negedge clockm_);
		check_half("zp (hi)", zp, exp[0:15]);
		@(posedge clockm_);
		zp_sel <= ZP_MID;
		@(negedge clockm_);
		check_half("zp (mid)", zp, exp[16:31]);
		@(posedge clockm_);
		zp_sel <= ZP_LOW;
		@(negedge clockm_);
		check_half("zp (low)", zp, {exp[32:39], d});
		check_flag("t_zero_hi", t_zero_hi, exp[0:15] == 16'h0);
		check_flag("t_zero_mid", t_zero_mid, exp[16:31] == 16'h0);
		check_flag("t_zero_low", t_zero_low, exp[32:39] == 8'h0);
		check_flag("t_sign", t_sign, exp[0]);
	endtask

	task automatic apply_row(input row_t r);
		@(posedge clockm_);
		w <= r.w1;
		fn_hi <= r.fn_hi;
		fn_lo <= r.fn_lo;
		{cin_a, cin_b, cin_c} <= r.cin;
		t_in <= r.t_in;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		@(posedge clockm_);
		w <= r.w2;
		// C takes the old T while T reloads
		run_op(T_LOAD, M_HOLD, C_LOAD, K_W);
		check_flag("cout_a", cout_a, r.cout[0]);
		check_flag("cout_b", cout_b, r.cout[1]);
		check_flag("cout_c", cout_c, r.cout[2]);
		run_op(T_LOAD, M_HOLD, C_HOLD, K_SUM);
		verify_t(r.exp);
		run_op(T_SHR, M_HOLD, C_HOLD, K_SUM);
		verify_t({r.t_in, r.exp[0:38]});
	endtask

	initial begin
		word_t tm;
		word_t mm;
		word_t cm;
		logic [0:2] co;
		int n;
		clockm_ = 1'b0;
		_0_t_ <= 1'b0;
		t_op <= T_HOLD;
		m_op <= M_HOLD;
		c_op <= C_HOLD;
		k_sel <= K_W;
		fn_hi <= ALU_ADD;
		fn_lo <= ALU_ADD;
		zp_sel <= ZP_HI;
		zp_clear <= 1'b0;
		{t_in, t_fill, m_in} <= 3'b000;
		{cin_a, cin_b, cin_c} <= 3'b000;
		w <= '0;
		d <= '0;
		{z_f, m_f, v_f, c_f} <= 4'b0000;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		rng = 32'd78;
		build_table();
		repeat (16) @(posedge clockm_);
		_0_t_ <= 1'b1;

		start_test("reset state");
		verify_t('0);
		check_flag("cout_a", cout_a, 1'b0);
		check_flag("cout_b", cout_b, 1'b0);
		check_flag("cout_c", cout_c, 1'b0);
		end_test();

		start_test("k bus load");
		@(posedge clockm_);
		w <= 16'hA5C3;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		verify_t(w_word(16'hA5C3));
		run_op(T_LOAD, M_HOLD, C_HOLD, K_ZERO);
		verify_t('0);
		end_test();

		start_test("segmented sum");
		for (int i = 0; i < NROWS; i++) begin
			apply_row(rows[i]);
		end
		end_test();

		start_test("shifts");
		@(posedge clockm_);
		t_in <= 1'b1;
		t_fill <= 1'b1;
		m_in <= 1'b0;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_ZERO);
		tm = '0;
		repeat (3) begin
			run_op(T_SHR, M_HOLD, C_HOLD, K_W);
			tm = {1'b1, tm[0:38]};
		end
		verify_t(tm);
		@(posedge clockm_);
		w <= 16'h0001;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		tm = w_word(16'h0001);
		// shift left until the set bit 15 reaches the sign
		n = 0;
		while (!t_sign && n < 40) begin
			run_op(T_SHL, M_HOLD, C_HOLD, K_W);
			tm = {tm[1:39], 1'b1};
			n++;
		end
		if (!t_sign) begin
			$display("timeout: t_sign did not rise within %0d left shifts", n);
			errors++;
		end else if (n != 15) begin
			$display("** Error at %0t ns: left shift count = %0d, expected 15", $time, n);
			errors++;
		end
		verify_t(tm);
		@(posedge clockm_);
		w <= 16'h8001;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		mm = w_word(16'h8001);
		run_op(T_HOLD, M_LOAD, C_HOLD, K_W);
		check_flag("m_sign", m_sign, mm[0]);
		repeat (2) begin
			run_op(T_HOLD, M_SHR, C_HOLD, K_W);
			mm = {1'b0, mm[0:38]};
			check_flag("m_sign", m_sign, mm[0]);
		end
		run_op(T_LOAD, M_HOLD, C_HOLD, K_M);
		verify_t(mm);
		@(posedge clockm_);
		w <= 16'h8421;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		run_op(T_HOLD, M_HOLD, C_LOAD, K_W);
		cm = w_word(16'h8421);
		repeat (5) begin
			run_op(T_HOLD, M_HOLD, C_SAR, K_W);
			cm = {cm[0], cm[0:38]};
			check_flag("c_sign", c_sign, cm[0]);
		end
		// C shows up in T as 0 + C
		@(posedge clockm_);
		fn_hi <= ALU_ADD;
		fn_lo <= ALU_ADD;
		{cin_a, cin_b, cin_c} <= 3'b000;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_ZERO);
		run_op(T_LOAD, M_HOLD, C_HOLD, K_SUM);
		verify_t(cm);
		end_test();

		start_test("zp readout");
		@(posedge clockm_);
		w <= 16'h3C5A;
		d <= 8'hE7;
		{z_f, m_f, v_f, c_f} <= 4'b1011;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		verify_t(w_word(16'h3C5A));
		@(posedge clockm_);
		zp_sel <= ZP_FLAGS;
		@(negedge clockm_);
		check_half("zp (flags)", zp, 16'hB000);
		for (int s = 0; s < 4; s++) begin
			@(posedge clockm_);
			zp_clear <= 1'b1;
			zp_sel <= zp_sel_t'(s[1:0]);
			@(negedge clockm_);
			check_half("zp (clear)", zp, 16'h0000);
		end
		end_test();

		start_test("zero detects");
		@(posedge clockm_);
		w <= 16'h00FF;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		verify_t(w_word(16'h00FF));
		@(posedge clockm_);
		w <= 16'h1234;
		fn_hi <= ALU_SUB;
		fn_lo <= ALU_PASS;
		{cin_a, cin_b, cin_c} <= 3'b100;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		run_op(T_HOLD, M_HOLD, C_LOAD, K_W);
		tm = w_word(16'h1234);
		seg_model(tm, tm, ALU_SUB, ALU_PASS, 3'b100, mm, co);
		check_flag("cout_a", cout_a, co[0]);
		check_flag("cout_b", cout_b, co[1]);
		check_flag("cout_c", cout_c, co[2]);
		run_op(T_LOAD, M_HOLD, C_HOLD, K_SUM);
		verify_t(mm);
		@(posedge clockm_);
		fn_hi <= ALU_PASS;
		fn_lo <= ALU_SUB;
		{cin_a, cin_b, cin_c} <= 3'b010;
		run_op(T_LOAD, M_HOLD, C_HOLD, K_W);
		seg_model(tm, tm, ALU_PASS, ALU_SUB, 3'b010, mm, co);
		check_flag("cout_a", cout_a, co[0]);
		check_flag("cout_b", cout_b, co[1]);
		check_flag("cout_c", cout_c, co[2]);
		run_op(T_LOAD, M_HOLD, C_HOLD, K_SUM);
		verify_t(mm);
		end_test();

		$display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
